// File: common/ines_format_pkg.sv
// iNES cartridge header format used by the header parser and the ROM loader
// Byte offsets, signature values, page sizes and the packed mapper flag word

package ines_format_pkg;

	localparam int HEADER_BYTES = 16;

	// "NES" followed by the MS-DOS end-of-file marker
	localparam logic [7:0] SIG_N   = 8'h4E;
	localparam logic [7:0] SIG_E   = 8'h45;
	localparam logic [7:0] SIG_S   = 8'h53;
	localparam logic [7:0] SIG_EOF = 8'h1A;

	// Header byte offsets
	localparam int HDR_PRG_PAGES = 4;
	localparam int HDR_CHR_PAGES = 5;
	localparam int HDR_FLAGS6    = 6;  // Mirroring, battery, trainer, four-screen, mapper low
	localparam int HDR_FLAGS7    = 7;  // Format id and mapper high nibble
	localparam int HDR_SUBMAPPER = 8;
	localparam int HDR_FLAGS9    = 9;
	localparam int HDR_PAD_FIRST = 10; // Bytes 10 to 15 are zero in a clean iNES 1.0 header

	localparam int PRG_PAGE_BYTES = 16384;
	localparam int CHR_PAGE_BYTES = 8192;

	// [7:0] mapper, [10:8] PRG size code, [13:11] CHR size code, [14] mirroring,
	// [15] CHR RAM, [16] four-screen, [24:17] submapper byte, [25] battery
	typedef logic [31:0] mapper_flags_t;

endpackage

// File: common/load_map_pkg.sv
// Memory map and common types of the cartridge loading front end
// Shared by the file type decoder, both loaders and the memory write port

package load_map_pkg;

	typedef logic [21:0] mem_addr_t;
	typedef logic [7:0]  byte_t;

	////////////////////////////////////////////////////////////
	// External memory map
	////////////////////////////////////////////////////////////

	localparam mem_addr_t PRG_BASE = 22'h000000;
	localparam mem_addr_t CHR_BASE = 22'h200000; // CHR lives in the upper half

	// Colour table download, 64 entries of 3 bytes
	localparam int PAL_BYTES = 192;

	typedef logic [14:0] pal_color_t;
	typedef logic [5:0]  pal_index_t;

	typedef enum logic [1:0] {
		NONE,
		ROM,
		PALETTE
	} file_kind_t;

	typedef enum logic [2:0] {
		HEADER,
		PRG,
		CHR,
		DONE,
		ERROR
	} loader_state_t;

	// Writes the memory accepts before it has to return a credit
	localparam int MEM_CREDITS = 4;

	typedef logic [2:0] credit_cnt_t;

endpackage

// File: common/mem_write_if.sv
// One byte write from the ROM loader towards the external memory port
// The port answers with stall while it cannot take another write

interface mem_write_if;

	logic                    wr;
	load_map_pkg::mem_addr_t addr;
	load_map_pkg::byte_t     data;
	logic                    stall;

	modport loader (
		output wr,
		output addr,
		output data,
		input  stall
	);

	modport port (
		input  wr,
		input  addr,
		input  data,
		output stall
	);

endinterface

// File: design/file_type_decoder.sv
// Classifies the download from its index and restarts the ROM loader
// Kind follows the index one cycle later, restart pulses at a ROM download start

module file_type_decoder (
	input  logic                     clk,
	input  logic                     reset_nes,
	input  logic                     dl_active,
	input  logic [7:0]               dl_index,
	output load_map_pkg::file_kind_t kind,
	output logic                     loader_restart
);

	load_map_pkg::file_kind_t index_kind;
	logic                     active_q;

	always_comb begin
		index_kind = load_map_pkg::NONE;
		if ((dl_index[5:0] == 6'd0 && dl_index[7:6] == 2'b01) ||
		    (dl_index[2:0] == 3'b001 && dl_index[7:6] == 2'b00))
			index_kind = load_map_pkg::ROM;
		else if (dl_index[2:0] == 3'b011)
			index_kind = load_map_pkg::PALETTE;
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			kind           <= load_map_pkg::NONE;
			active_q       <= 1'b0;
			loader_restart <= 1'b0;
		end else begin
			kind           <= index_kind;
			active_q       <= dl_active;
			loader_restart <= dl_active && !active_q && (kind == load_map_pkg::ROM);
		end
	end

	// A palette download never restarts the ROM loader
	a_no_restart_on_palette : assert property (@(posedge clk) disable iff (reset_nes)
		!(kind == load_map_pkg::PALETTE && loader_restart));

endmodule

// File: loader/ines_header_parser.sv
// Holds the 16 iNES header bytes and decodes them for the ROM loader
// Validity and page counts are ready when the last header byte arrives

module ines_header_parser (
	input  logic                           clk,
	input  logic                           reset_nes,
	input  logic                           capture,
	input  logic [3:0]                     hdr_offset,
	input  load_map_pkg::byte_t            hdr_byte,
	input  logic                           invert_mirroring,
	output logic                           header_ok,
	output load_map_pkg::byte_t            prg_pages,
	output load_map_pkg::byte_t            chr_pages,
	output ines_format_pkg::mapper_flags_t flags
);

	load_map_pkg::byte_t hdr [ines_format_pkg::HEADER_BYTES];
	load_map_pkg::byte_t flags6;
	load_map_pkg::byte_t flags7;
	load_map_pkg::byte_t submapper;
	logic                is_nes20;
	logic                is_dirty;
	logic                pad_nonzero;
	logic [3:0]          mapper_hi;

	// Smallest k with pages <= 2^k, capped at 7
	function automatic logic [2:0] size_code(input load_map_pkg::byte_t pages);
		logic [2:0] code;
		code = 3'd7;
		for (int k = 6; k >= 0; k--) begin
			if (pages <= (9'd1 << k))
				code = 3'(k);
		end
		return code;
	endfunction

	always_ff @(posedge clk) begin
		if (reset_nes)
			hdr <= '{default: '0};
		else if (capture)
			hdr[hdr_offset] <= hdr_byte;
	end

	assign flags6    = hdr[ines_format_pkg::HDR_FLAGS6];
	assign flags7    = hdr[ines_format_pkg::HDR_FLAGS7];
	assign prg_pages = hdr[ines_format_pkg::HDR_PRG_PAGES];
	assign chr_pages = hdr[ines_format_pkg::HDR_CHR_PAGES];

	// Signature check, trainers are not supported
	assign header_ok = (hdr[0] == ines_format_pkg::SIG_N) && (hdr[1] == ines_format_pkg::SIG_E) &&
	                   (hdr[2] == ines_format_pkg::SIG_S) && (hdr[3] == ines_format_pkg::SIG_EOF) &&
	                   !flags6[2];

	always_comb begin
		pad_nonzero = 1'b0;
		for (int i = ines_format_pkg::HDR_PAD_FIRST; i < ines_format_pkg::HEADER_BYTES; i++) begin
			pad_nonzero = pad_nonzero || (hdr[i] != '0);
		end
	end

	assign is_nes20  = (flags7[3:2] == 2'b10);
	assign is_dirty  = !is_nes20 && ((hdr[ines_format_pkg::HDR_FLAGS9][7:1] != '0) || pad_nonzero);
	assign mapper_hi = is_dirty ? 4'd0 : flags7[7:4]; // Junk in old dumps, drop it
	assign submapper = is_nes20 ? hdr[ines_format_pkg::HDR_SUBMAPPER] : 8'd0;

	assign flags = {
		6'd0,
		flags6[1],                     // Battery saves
		submapper,
		flags6[3],                     // Four-screen
		(chr_pages == 8'd0),           // CHR RAM
		flags6[0] ^ invert_mirroring,
		size_code(chr_pages),
		size_code(prg_pages),
		mapper_hi,
		flags6[7:4]
	};

endmodule

// File: loader/rom_loader_fsm.sv
// Walks a ROM download through header, PRG and CHR sections
// Body bytes go out as memory writes, PRG from PRG_BASE and CHR from CHR_BASE
// Header bytes only feed the parser and are never written to memory

module rom_loader_fsm (
	input  logic                           clk,
	input  logic                           reset_nes,
	input  logic                           restart,
	input  load_map_pkg::file_kind_t       kind,
	input  logic                           dl_valid,
	input  load_map_pkg::byte_t            dl_data,
	input  logic                           header_ok,
	input  load_map_pkg::byte_t            prg_pages,
	input  load_map_pkg::byte_t            chr_pages,
	input  ines_format_pkg::mapper_flags_t flags,
	output logic                           capture,
	output logic [3:0]                     hdr_offset,
	output load_map_pkg::byte_t            hdr_byte,
	output logic                           busy,
	output logic                           done,
	output logic                           error,
	output ines_format_pkg::mapper_flags_t mapper_flags,
	mem_write_if.loader                    mem_wr
);

	load_map_pkg::loader_state_t state;
	logic [3:0]                  hdr_count;
	load_map_pkg::mem_addr_t     bytes_left;
	load_map_pkg::mem_addr_t     wr_addr;
	load_map_pkg::mem_addr_t     prg_bytes;
	load_map_pkg::mem_addr_t     chr_bytes;
	logic                        rom_byte;
	logic                        last_hdr;
	logic                        last_body;

	assign rom_byte  = dl_valid && (kind == load_map_pkg::ROM);
	assign prg_bytes = load_map_pkg::mem_addr_t'(prg_pages * ines_format_pkg::PRG_PAGE_BYTES);
	assign chr_bytes = load_map_pkg::mem_addr_t'(chr_pages * ines_format_pkg::CHR_PAGE_BYTES);
	assign last_hdr  = (hdr_count == 4'(ines_format_pkg::HEADER_BYTES - 1));
	assign last_body = (bytes_left == load_map_pkg::mem_addr_t'(1));

	assign capture    = rom_byte && busy && (state == load_map_pkg::HEADER);
	assign hdr_offset = hdr_count;
	assign hdr_byte   = dl_data;

	assign mem_wr.wr   = rom_byte && (state == load_map_pkg::PRG || state == load_map_pkg::CHR);
	assign mem_wr.addr = wr_addr;
	assign mem_wr.data = dl_data;

	////////////////////////////////////////////////////////////
	// Section sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state        <= load_map_pkg::HEADER;
			hdr_count    <= 4'd0;
			bytes_left   <= '0;
			wr_addr      <= load_map_pkg::PRG_BASE;
			busy         <= 1'b0;
			done         <= 1'b0;
			error        <= 1'b0;
			mapper_flags <= '0;
		end else if (restart) begin
			state     <= load_map_pkg::HEADER;
			hdr_count <= 4'd0;
			busy      <= 1'b1;
			done      <= 1'b0;
			error     <= 1'b0;
		end else begin
			case (state)
				load_map_pkg::HEADER: begin
					if (capture) begin
						hdr_count <= hdr_count + 4'd1;
						// Bytes 0 to 6 are already stored, enough to pick the next section
						if (last_hdr) begin
							if (!header_ok) begin
								state <= load_map_pkg::ERROR;
							end else if (prg_pages != 8'd0) begin
								state      <= load_map_pkg::PRG;
								bytes_left <= prg_bytes;
								wr_addr    <= load_map_pkg::PRG_BASE;
							end else if (chr_pages != 8'd0) begin
								state      <= load_map_pkg::CHR;
								bytes_left <= chr_bytes;
								wr_addr    <= load_map_pkg::CHR_BASE;
							end else begin
								state <= load_map_pkg::DONE;
							end
						end
					end
				end
				load_map_pkg::PRG, load_map_pkg::CHR: begin
					if (mem_wr.wr) begin
						bytes_left <= bytes_left - load_map_pkg::mem_addr_t'(1);
						wr_addr    <= wr_addr + load_map_pkg::mem_addr_t'(1);
						if (last_body) begin
							if (state == load_map_pkg::PRG && chr_pages != 8'd0) begin
								state      <= load_map_pkg::CHR;
								bytes_left <= chr_bytes;
								wr_addr    <= load_map_pkg::CHR_BASE;
							end else begin
								state <= load_map_pkg::DONE; // No CHR ROM means CHR RAM
							end
						end
					end
				end
				load_map_pkg::DONE, load_map_pkg::ERROR: begin
					busy  <= 1'b0;
					done  <= 1'b1;
					error <= (state == load_map_pkg::ERROR);
					if (!done)
						mapper_flags <= flags; // Published together with done
				end
				default: state <= load_map_pkg::ERROR;
			endcase
		end
	end

	// Source holds off on dl_wait, so a body byte never meets a stalled port
	a_no_wr_on_stall : assert property (@(posedge clk) disable iff (reset_nes)
		!(mem_wr.wr && mem_wr.stall));

endmodule

// File: design/credit_write_port.sv
// Registered memory write port with credit based flow control
// A loader write leaves one cycle later, stall and dl_wait hold off the source

module credit_write_port (
	input  logic                    clk,
	input  logic                    reset_nes,
	input  logic                    mem_credit,
	mem_write_if.port               mem_wr,
	output logic                    mem_wr_valid,
	output load_map_pkg::mem_addr_t mem_wr_addr,
	output load_map_pkg::byte_t     mem_wr_data,
	output logic                    dl_wait
);

	load_map_pkg::credit_cnt_t credits;
	logic                      no_credit;

	assign no_credit = (credits == '0);

	// A write in flight has not yet taken its credit
	assign mem_wr.stall = no_credit || mem_wr_valid;
	assign dl_wait      = mem_wr.stall;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			mem_wr_valid <= 1'b0;
			credits      <= load_map_pkg::credit_cnt_t'(load_map_pkg::MEM_CREDITS);
		end else begin
			mem_wr_valid <= mem_wr.wr;
			case ({mem_wr_valid, mem_credit})
				2'b10:   credits <= credits - load_map_pkg::credit_cnt_t'(1);
				2'b01:   credits <= credits + load_map_pkg::credit_cnt_t'(1);
				default: credits <= credits; // Both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (mem_wr.wr) begin
			mem_wr_addr <= mem_wr.addr;
			mem_wr_data <= mem_wr.data;
		end
	end

	// The memory never returns more credits than it was granted
	a_credit_limit : assert property (@(posedge clk) disable iff (reset_nes)
		credits <= load_map_pkg::credit_cnt_t'(load_map_pkg::MEM_CREDITS));

endmodule

// File: design/palette_loader.sv
// Packs a palette download into 15-bit colour table writes
// Three bytes per entry, the top 5 bits of each byte form one colour field

module palette_loader (
	input  logic                     clk,
	input  logic                     reset_nes,
	input  load_map_pkg::file_kind_t kind,
	input  logic                     dl_active,
	input  logic                     dl_valid,
	input  load_map_pkg::byte_t      dl_data,
	output logic                     pal_write,
	output load_map_pkg::pal_index_t pal_index,
	output load_map_pkg::pal_color_t pal_color
);

	logic [1:0]               phase;
	load_map_pkg::byte_t      offset;
	load_map_pkg::pal_index_t group;
	logic [9:0]               color_lo;
	logic                     pal_byte;

	assign pal_byte = dl_active && dl_valid && (kind == load_map_pkg::PALETTE) &&
	                  (offset < load_map_pkg::byte_t'(load_map_pkg::PAL_BYTES));

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			phase     <= 2'd0;
			offset    <= '0;
			group     <= '0;
			pal_write <= 1'b0;
		end else begin
			pal_write <= pal_byte && (phase == 2'd2);
			if (!dl_active) begin
				phase  <= 2'd0;
				offset <= '0;
				group  <= '0;
			end else if (pal_byte) begin
				offset <= offset + 8'd1;
				if (phase == 2'd2) begin
					phase <= 2'd0;
					group <= group + 6'd1;
				end else begin
					phase <= phase + 2'd1;
				end
			end
		end
	end

	// Colour fields, red first
	always_ff @(posedge clk) begin
		if (pal_byte) begin
			case (phase)
				2'd0: color_lo[4:0] <= dl_data[7:3];
				2'd1: color_lo[9:5] <= dl_data[7:3];
				default: begin
					pal_color <= {dl_data[7:3], color_lo};
					pal_index <= group;
				end
			endcase
		end
	end

endmodule

// File: design/nes_loader_top.sv
// Cartridge loading front end of the NES core
// Takes the download byte stream and produces memory writes, mapper flags
// and colour table writes

module nes_loader_top (
	input  logic                           clk,
	input  logic                           reset_nes,
	input  logic                           dl_active,
	input  logic [7:0]                     dl_index,
	input  logic                           dl_valid,
	input  load_map_pkg::byte_t            dl_data,
	input  logic                           invert_mirroring,
	input  logic                           mem_credit,
	output logic                           dl_wait,
	output logic                           mem_wr_valid,
	output load_map_pkg::mem_addr_t        mem_wr_addr,
	output load_map_pkg::byte_t            mem_wr_data,
	output logic                           busy,
	output logic                           done,
	output logic                           error,
	output ines_format_pkg::mapper_flags_t mapper_flags,
	output logic                           pal_write,
	output load_map_pkg::pal_index_t       pal_index,
	output load_map_pkg::pal_color_t       pal_color
);

	load_map_pkg::file_kind_t       kind;
	logic                           loader_restart;
	logic                           capture;
	logic [3:0]                     hdr_offset;
	load_map_pkg::byte_t            hdr_byte;
	logic                           header_ok;
	load_map_pkg::byte_t            prg_pages;
	load_map_pkg::byte_t            chr_pages;
	ines_format_pkg::mapper_flags_t flags;

	mem_write_if i_mem_wr ();

	////////////////////////////////////////////////////////////
	// File type and ROM path
	////////////////////////////////////////////////////////////

	file_type_decoder i_file_type_decoder (
		.clk            (clk),
		.reset_nes      (reset_nes),
		.dl_active      (dl_active),
		.dl_index       (dl_index),
		.kind           (kind),
		.loader_restart (loader_restart)
	);

	ines_header_parser i_ines_header_parser (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.capture          (capture),
		.hdr_offset       (hdr_offset),
		.hdr_byte         (hdr_byte),
		.invert_mirroring (invert_mirroring),
		.header_ok        (header_ok),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages),
		.flags            (flags)
	);

	rom_loader_fsm i_rom_loader_fsm (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.restart      (loader_restart),
		.kind         (kind),
		.dl_valid     (dl_valid),
		.dl_data      (dl_data),
		.header_ok    (header_ok),
		.prg_pages    (prg_pages),
		.chr_pages    (chr_pages),
		.flags        (flags),
		.capture      (capture),
		.hdr_offset   (hdr_offset),
		.hdr_byte     (hdr_byte),
		.busy         (busy),
		.done         (done),
		.error        (error),
		.mapper_flags (mapper_flags),
		.mem_wr       (i_mem_wr.loader)
	);

	credit_write_port i_credit_write_port (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.mem_credit   (mem_credit),
		.mem_wr       (i_mem_wr.port),
		.mem_wr_valid (mem_wr_valid),
		.mem_wr_addr  (mem_wr_addr),
		.mem_wr_data  (mem_wr_data),
		.dl_wait      (dl_wait)
	);

	// Palette path
	palette_loader i_palette_loader (
		.clk       (clk),
		.reset_nes (reset_nes),
		.kind      (kind),
		.dl_active (dl_active),
		.dl_valid  (dl_valid),
		.dl_data   (dl_data),
		.pal_write (pal_write),
		.pal_index (pal_index),
		.pal_color (pal_color)
	);

endmodule

// File: tests/tb_nes_loader.sv
// Self-checking testbench of the cartridge loading front end
// Reads one download per line from tests/loader_testdata.txt, streams it into the DUT
// and checks memory writes, palette writes, status and mapper flags

module tb_nes_loader;

	localparam int MAX_TESTS = 16;

	logic        clk;
	logic        reset_nes;
	logic        dl_active;
	logic [7:0]  dl_index;
	logic        dl_valid;
	logic [7:0]  dl_data;
	logic        invert_mirroring;
	logic        mem_credit;
	logic        dl_wait;
	logic        mem_wr_valid;
	logic [21:0] mem_wr_addr;
	logic [7:0]  mem_wr_data;
	logic        busy;
	logic        done;
	logic        error;
	logic [31:0] mapper_flags;
	logic        pal_write;
	logic [5:0]  pal_index;
	logic [14:0] pal_color;

	// Test table as read from the data file
	string       t_name   [MAX_TESTS];
	logic [7:0]  t_index  [MAX_TESTS];
	int          t_invert [MAX_TESTS];
	int          t_credit [MAX_TESTS]; // 0 prompt, 1 held back, 2 random
	logic [7:0]  t_seed   [MAX_TESTS];
	int          t_error  [MAX_TESTS];
	logic [31:0] t_flags  [MAX_TESTS];
	logic [7:0]  t_hdr    [MAX_TESTS][16];
	int          num_tests;

	int cur;
	int pass_count;
	int fail_count;
	bit test_failed;
	int wr_seen;
	int pal_seen;
	int outstanding;  // Writes the memory model has not yet answered with a credit
	int hold_cycles;
	bit draining;
	bit src_done;
	bit wait_seen;
	int prg_bytes;
	int chr_bytes;
	int limit_cycles;

	nes_loader_top i_dut (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.dl_active        (dl_active),
		.dl_index         (dl_index),
		.dl_valid         (dl_valid),
		.dl_data          (dl_data),
		.invert_mirroring (invert_mirroring),
		.mem_credit       (mem_credit),
		.dl_wait          (dl_wait),
		.mem_wr_valid     (mem_wr_valid),
		.mem_wr_addr      (mem_wr_addr),
		.mem_wr_data      (mem_wr_data),
		.busy             (busy),
		.done             (done),
		.error            (error),
		.mapper_flags     (mapper_flags),
		.pal_write        (pal_write),
		.pal_index        (pal_index),
		.pal_color        (pal_color)
	);

	always #20 clk = ~clk;

	// Body byte at a file offset
	function automatic logic [7:0] body_byte(input int offset);
		return 8'(offset) ^ t_seed[cur];
	endfunction

	function automatic logic [31:0] expected_addr(input int k);
		if (k < prg_bytes)
			return 32'(load_map_pkg::PRG_BASE) + 32'(k);
		return 32'(load_map_pkg::CHR_BASE) + 32'(k - prg_bytes);
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
	                           input logic [31:0] actual);
		assert (expected == actual) else begin
			$display("** Error %0s %0s: expected %h, actual %h", t_name[cur], what, expected,
			         actual);
			test_failed = 1'b1;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Output monitor and memory credit model
	////////////////////////////////////////////////////////////

	task automatic observe();
		int         k;
		bit         give;
		logic [7:0] b0;
		logic [7:0] b1;
		logic [7:0] b2;
		give = 1'b0;
		if (mem_wr_valid) begin
			k = wr_seen;
			check_value("write address", expected_addr(k), mem_wr_addr);
			check_value("write data", body_byte(ines_format_pkg::HEADER_BYTES + k), mem_wr_data);
			wr_seen++;
			outstanding++;
		end
		if (pal_write) begin
			b0 = body_byte(3 * pal_seen);
			b1 = body_byte(3 * pal_seen + 1);
			b2 = body_byte(3 * pal_seen + 2);
			check_value("palette index", pal_seen % 64, pal_index);
			check_value("palette colour", {b2[7:3], b1[7:3], b0[7:3]}, pal_color);
			pal_seen++;
		end
		if (dl_wait && !mem_wr_valid)
			wait_seen = 1'b1; // Out of credits
		if (outstanding > 0) begin
			case (t_credit[cur])
				0: give = 1'b1;
				1: begin
					// Sit on a full window for a while, then hand everything back
					if (!draining && (outstanding >= load_map_pkg::MEM_CREDITS || src_done)) begin
						hold_cycles++;
						draining = (hold_cycles >= 12);
					end
					give = draining;
				end
				default: give = ($urandom % 4 == 0);
			endcase
		end
		mem_credit = give;
		if (give) begin
			outstanding--;
			if (outstanding == 0) begin
				draining    = 1'b0;
				hold_cycles = 0;
			end
		end
	endtask

	task automatic tick();
		@(negedge clk);
		observe();
	endtask

	////////////////////////////////////////////////////////////
	// One download
	////////////////////////////////////////////////////////////

	task automatic run_test(input int t);
		int total;
		int sent;
		int exp_writes;
		int exp_pal;
		bit is_pal;
		cur         = t;
		wr_seen     = 0;
		pal_seen    = 0;
		hold_cycles = 0;
		draining    = 1'b0;
		src_done    = 1'b0;
		wait_seen   = 1'b0;
		test_failed = 1'b0;
		is_pal      = (t_index[t][2:0] == 3'b011);
		prg_bytes   = int'(t_hdr[t][4]) * ines_format_pkg::PRG_PAGE_BYTES;
		chr_bytes   = int'(t_hdr[t][5]) * ines_format_pkg::CHR_PAGE_BYTES;
		if (is_pal) begin
			total      = int'(t_hdr[t][0]);
			exp_writes = 0;
			exp_pal    = ((total < load_map_pkg::PAL_BYTES) ? total : load_map_pkg::PAL_BYTES) / 3;
		end else begin
			total      = ines_format_pkg::HEADER_BYTES + prg_bytes + chr_bytes;
			exp_writes = (t_error[t] != 0) ? 0 : prg_bytes + chr_bytes;
			exp_pal    = 0;
		end

		dl_index         = t_index[t];
		invert_mirroring = t_invert[t][0];
		repeat (2) tick();
		dl_active = 1'b1;
		repeat (3) tick(); // Let the restart reach the loader
		sent = 0;
		while (sent < total) begin
			if (!dl_wait) begin
				dl_valid = 1'b1;
				dl_data  = (!is_pal && sent < 16) ? t_hdr[t][sent] : body_byte(sent);
				sent++;
			end else begin
				dl_valid = 1'b0;
			end
			tick();
		end
		dl_valid = 1'b0;
		src_done = 1'b1;

		if (is_pal) begin
			repeat (2) tick(); // Last pal_write trails its byte by one cycle
		end else begin
			while (!done)
				tick();
			// Flags are published in the cycle done rises
			check_value("error", t_error[t], error);
			if (t_error[t] == 0)
				check_value("mapper_flags", t_flags[t], mapper_flags);
			while (outstanding > 0)
				tick();
			check_value("busy", 0, busy);
		end
		check_value("write count", exp_writes, wr_seen);
		check_value("palette write count", exp_pal, pal_seen);
		if (t_credit[t] == 1) begin
			assert (wait_seen) else begin
				$display("%0s: dl_wait never rose while the memory held its credits", t_name[t]);
				test_failed = 1'b1;
			end
		end

		dl_active = 1'b0;
		repeat (3) tick();
		if (test_failed) begin
			fail_count++;
			$display("FAIL %0s", t_name[t]);
		end else begin
			pass_count++;
			$display("PASS %0s", t_name[t]);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int    fd;
		int    n;
		int    total_bytes;
		string line;
		void'($urandom(14));
		clk              = 1'b0;
		reset_nes        = 1'b1;
		dl_active        = 1'b0;
		dl_index         = 8'd0;
		dl_valid         = 1'b0;
		dl_data          = 8'd0;
		invert_mirroring = 1'b0;
		mem_credit       = 1'b0;
		cur              = 0;
		pass_count       = 0;
		fail_count       = 0;
		outstanding      = 0;
		num_tests        = 0;
		total_bytes      = 0;

		fd = $fopen("tests/loader_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open tests/loader_testdata.txt");
			fail_count++;
		end else begin
			while (!$feof(fd) && num_tests < MAX_TESTS) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 1 && line.getc(0) != "#") begin
					n = $sscanf(line,
						"%s %h %d %d %h %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						t_name[num_tests], t_index[num_tests], t_invert[num_tests],
						t_credit[num_tests], t_seed[num_tests], t_error[num_tests],
						t_flags[num_tests],
						t_hdr[num_tests][0], t_hdr[num_tests][1], t_hdr[num_tests][2],
						t_hdr[num_tests][3], t_hdr[num_tests][4], t_hdr[num_tests][5],
						t_hdr[num_tests][6], t_hdr[num_tests][7], t_hdr[num_tests][8],
						t_hdr[num_tests][9], t_hdr[num_tests][10], t_hdr[num_tests][11],
						t_hdr[num_tests][12], t_hdr[num_tests][13], t_hdr[num_tests][14],
						t_hdr[num_tests][15]);
					if (n == 23) begin
						if (t_index[num_tests][2:0] == 3'b011)
							total_bytes += int'(t_hdr[num_tests][0]);
						else
							total_bytes += 16 + int'(t_hdr[num_tests][4]) * 16384 +
							               int'(t_hdr[num_tests][5]) * 8192;
						num_tests++;
					end else begin
						$display("malformed test data line: %0s", line);
						fail_count++;
					end
				end
			end
			$fclose(fd);
		end
		limit_cycles = 10 * total_bytes + 100 * num_tests + 100;

		repeat (4) @(negedge clk);
		reset_nes = 1'b0;
		@(negedge clk);

		// Status outputs idle straight out of reset
		assert ({mem_wr_valid, dl_wait, busy, done, error, pal_write} == 6'd0) else begin
			$display("** Error reset: expected 000000, actual %b",
			         {mem_wr_valid, dl_wait, busy, done, error, pal_write});
			fail_count++;
		end

		for (int t = 0; t < num_tests; t++)
			run_test(t);

		$display("%0d tests run, %0d passed, %0d failed", num_tests, pass_count, fail_count);
		if (fail_count == 0 && num_tests > 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// Ten cycles per streamed byte covers the slowest credit pattern
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the DUT stopped responding", limit_cycles);
		$display("tests failed");
		$finish;
	end

endmodule

// File: tests/loader_testdata.txt
# name index invert credit seed error flags h0..h15; index, seed, flags and header bytes in hex
# credit 0 returns at once, 1 holds back a full window, 2 random; a palette line has its byte count in h0
rom_chr_prompt   01 0 0 5a 0 00004000 4e 45 53 1a 01 01 01 00 00 00 00 00 00 00 00 00
chr_ram          40 0 0 3c 0 02008101 4e 45 53 1a 02 00 12 00 00 00 00 00 00 00 00 00
bad_signature    01 0 0 11 1 00000000 4e 45 54 1a 01 00 00 00 00 00 00 00 00 00 00 00
trainer_set      01 0 0 22 1 00000000 4e 45 53 1a 01 00 04 00 00 00 00 00 00 00 00 00
dirty_header     09 1 0 c3 0 00004004 4e 45 53 1a 01 01 40 a0 00 00 00 00 00 00 44 00
nes20_submapper  01 0 0 96 0 000a4842 4e 45 53 1a 01 02 21 48 05 00 00 00 00 07 00 00
four_screen_inv  11 1 0 e7 0 00010211 4e 45 53 1a 03 01 19 10 00 00 00 00 00 00 00 00
withheld_credits 01 0 1 a5 0 00004000 4e 45 53 1a 01 01 01 00 00 00 00 00 00 00 00 00
random_credits   09 0 2 77 0 00000000 4e 45 53 1a 01 01 00 00 00 00 00 00 00 00 00 00
palette_short    03 0 0 1f 0 00000000 30 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
palette_full     0b 0 0 6d 0 00000000 c6 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00

// File: verilog.f
common/ines_format_pkg.sv
common/load_map_pkg.sv
common/mem_write_if.sv
design/file_type_decoder.sv
loader/ines_header_parser.sv
loader/rom_loader_fsm.sv
design/credit_write_port.sv
design/palette_loader.sv
design/nes_loader_top.sv
tests/tb_nes_loader.sv

// File: run_sim.sh
#!/bin/sh
# Builds the loader testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_nes_loader \
	-f verilog.f -o sim_nes_loader

output=$(./obj_dir/sim_nes_loader)
echo "$output"

if echo "$output" | grep -q "^all tests passed$"; then
	exit 0
fi
exit 1
